//--- sifhGeomPkg.sv
package sifhGeomPkg;

    localparam int timeBits  = 12;
    localparam int binBits   = 4;     // 16 bins per pixel
    localparam int pixelBits = 3;     // up to 8 pixels
    localparam int countBits = 8;

    localparam int numBins   = 1 << binBits;
    localparam int maxPixels = 1 << pixelBits;
    localparam int addrBits  = pixelBits + binBits;
    localparam int ramDepth  = maxPixels * numBins;

    typedef logic [timeBits-1:0]  timeT;
    typedef logic [binBits-1:0]   binT;
    typedef logic [pixelBits-1:0] pixelT;

    // pixel index sits above the bin index
    typedef logic [addrBits-1:0]  ramAddrT;

    typedef logic [countBits-1:0] countT;

    // saturation level of a bin
    localparam countT countMax = '1;

endpackage

//--- sifhCtrlPkg.sv
package sifhCtrlPkg;

    import sifhGeomPkg::*;

    // engine phases
    typedef enum logic [1:0] {
        clearing,
        acquiring,
        scanning,
        draining
    } fsmStateT;

    // one photon hit from the array
    typedef struct packed {
        pixelT pixel;
        timeT  timestamp;   // top binBits select the bin
    } hitT;

    // RAM write port
    typedef struct packed {
        logic    en;
        ramAddrT addr;
        countT   data;
    } ramWrT;

    // per-pixel scan result
    typedef struct packed {
        pixelT pixel;
        binT   bin;
        countT count;
    } peakT;

endpackage

//--- histRam.sv
`timescale 1ns/1ns

module histRam
    import sifhGeomPkg::*;
    import sifhCtrlPkg::*;
(
    input  logic    clk,
    input  ramWrT   wr,
    input  logic    rdEn,
    input  ramAddrT rdAddr,
    output countT   rdData
);

    countT mem [ramDepth];   // one count per pixel/bin

    // write port
    always_ff @(posedge clk) begin
        if (wr.en) begin
            mem[wr.addr] <= wr.data;
        end
    end

    // registered read, old data on a same-edge write
    always_ff @(posedge clk) begin
        if (rdEn) begin
            rdData <= mem[rdAddr];
        end
    end

endmodule

//--- histFsm.sv
`timescale 1ns/1ns

module histFsm
    import sifhGeomPkg::*;
    import sifhCtrlPkg::*;
#(
    parameter int numPixels = maxPixels
)(
    input  logic    clk,
    input  logic    res,
    input  logic    hitValid,
    input  hitT     hit,
    input  logic    scan,
    input  countT   rdData,
    output ramWrT   wr,
    output logic    rdEn,
    output ramAddrT rdAddr,
    output logic    binValid,
    output logic    lastBin,
    output logic    ready
);

    // last used RAM entry for the active pixels
    localparam ramAddrT lastAddr = ramAddrT'(numPixels * numBins - 1);

    fsmStateT state;
    logic     armed;      // low on the first cycle of clear and scan
    ramAddrT  addrCnt;    // clear/scan address
    logic     atLast;

    logic     clrWr;
    logic     scanRd;

    // acquire pipeline
    logic     hitAcc;
    ramAddrT  hitAddr;
    logic     pend;       // increment due this cycle
    ramAddrT  pendAddr;
    logic     fwdEn;      // write of the previous cycle
    ramAddrT  fwdAddr;
    countT    fwdData;
    countT    base;
    countT    incData;

    assign hitAddr = {hit.pixel, hit.timestamp[timeBits-1 -: binBits]};
    assign hitAcc  = hitValid && ready && (hit.pixel < numPixels);

    assign atLast = (addrCnt == lastAddr);
    assign clrWr  = (state == clearing) && armed;
    assign scanRd = (state == scanning) && armed;

    // read port is shared by hits and the scan
    assign rdEn   = hitAcc || scanRd;
    assign rdAddr = scanRd ? addrCnt : hitAddr;

    // that write landed on the same edge as our read, so RAM data is stale
    assign base    = (fwdEn && (fwdAddr == pendAddr)) ? fwdData : rdData;
    assign incData = (base == countMax) ? base : base + 1'b1;   // saturate

    always_comb begin
        wr.en   = clrWr || pend;
        wr.addr = clrWr ? addrCnt : pendAddr;
        wr.data = clrWr ? '0 : incData;
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state   <= clearing;
            armed   <= 1'b0;
            addrCnt <= '0;
            ready   <= 1'b0;
        end else begin
            case (state)
                clearing, scanning: begin
                    if (!armed) begin
                        armed <= 1'b1;
                    end else if (atLast) begin
                        armed   <= 1'b0;
                        addrCnt <= '0;
                        if (state == clearing) begin
                            state <= acquiring;
                            ready <= 1'b1;   // high once the last zero is written
                        end else begin
                            state <= draining;
                        end
                    end else begin
                        addrCnt <= addrCnt + 1'b1;
                    end
                end

                acquiring: begin
                    if (scan && ready) begin
                        state <= scanning;   // a hit this cycle still goes through
                        ready <= 1'b0;
                    end
                end

                draining: begin
                    // final bin reaches the peak finder
                    if (lastBin) begin
                        state <= clearing;
                    end
                end

                default: state <= clearing;
            endcase
        end
    end

    // pipeline control and scan marks, one cycle behind the read
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            pend     <= 1'b0;
            fwdEn    <= 1'b0;
            binValid <= 1'b0;
            lastBin  <= 1'b0;
        end else begin
            pend     <= hitAcc;
            fwdEn    <= pend;
            binValid <= scanRd;
            lastBin  <= scanRd && (addrCnt[binBits-1:0] == '1);
        end
    end

    always_ff @(posedge clk) begin
        pendAddr <= hitAddr;
        fwdAddr  <= pendAddr;
        fwdData  <= incData;
    end

endmodule

//--- peakFinder.sv
`timescale 1ns/1ns

module peakFinder
    import sifhGeomPkg::*;
    import sifhCtrlPkg::*;
(
    input  logic  clk,
    input  logic  res,
    input  logic  binValid,
    input  logic  lastBin,
    input  countT rdData,
    output logic  peakValid,
    output peakT  peak
);

    binT   binIdx;     // bin within current pixel
    pixelT pixCnt;     // pixel being scanned
    countT maxCount;
    binT   maxBin;

    logic  takeNew;
    countT curMax;
    binT   curBin;

    // first bin loads, later ones only if strictly larger so ties keep the low bin
    assign takeNew = (binIdx == '0) || (rdData > maxCount);
    assign curMax  = takeNew ? rdData : maxCount;
    assign curBin  = takeNew ? binIdx : maxBin;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            binIdx    <= '0;
            pixCnt    <= '0;
            peakValid <= 1'b0;
        end else begin
            peakValid <= binValid && lastBin;
            if (binValid) begin
                if (lastBin) begin
                    binIdx <= '0;
                    pixCnt <= pixCnt + 1'b1;
                end else begin
                    binIdx <= binIdx + 1'b1;
                end
            end else begin
                binIdx <= '0;   // idle between scans
                pixCnt <= '0;
            end
        end
    end

    // running maximum and result register
    always_ff @(posedge clk) begin
        if (binValid) begin
            maxCount <= curMax;
            maxBin   <= curBin;
        end
        if (binValid && lastBin) begin
            peak.pixel <= pixCnt;
            peak.bin   <= curBin;
            peak.count <= curMax;
        end
    end

endmodule

//--- sifhTop.sv
`timescale 1ns/1ns

module sifhTop
    import sifhGeomPkg::*;
    import sifhCtrlPkg::*;
#(
    parameter int numPixels = maxPixels   // active pixels, 1 to maxPixels
)(
    input  logic clk,
    input  logic res,
    input  logic hitValid,
    input  hitT  hit,
    input  logic scan,
    output logic ready,
    output logic peakValid,
    output peakT peak
);

    ramWrT   wr;
    logic    rdEn;
    ramAddrT rdAddr;
    countT   rdData;
    logic    binValid;   // aligned with rdData
    logic    lastBin;

    histFsm #(
        .numPixels(numPixels)
    ) histFsm_i (
        .clk      (clk),
        .res      (res),
        .hitValid (hitValid),
        .hit      (hit),
        .scan     (scan),
        .rdData   (rdData),
        .wr       (wr),
        .rdEn     (rdEn),
        .rdAddr   (rdAddr),
        .binValid (binValid),
        .lastBin  (lastBin),
        .ready    (ready)
    );

    histRam histRam_i (
        .clk    (clk),
        .wr     (wr),
        .rdEn   (rdEn),
        .rdAddr (rdAddr),
        .rdData (rdData)
    );

    peakFinder peakFinder_i (
        .clk       (clk),
        .res       (res),
        .binValid  (binValid),
        .lastBin   (lastBin),
        .rdData    (rdData),
        .peakValid (peakValid),
        .peak      (peak)
    );

endmodule

//--- sifhTop_props.sv
`timescale 1ns/1ns

module sifhProps
    import sifhGeomPkg::*;
    import sifhCtrlPkg::*;
#(
    parameter int numPixels = maxPixels
)(
    input logic  clk,
    input logic  res,
    input logic  ready,
    input ramWrT wr,
    input logic  peakValid,
    input peakT  peak
);

    int    peakCnt;     // results already seen in this scan
    pixelT lastPixel;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            peakCnt   <= 0;
            lastPixel <= '0;
        end else if (ready) begin
            peakCnt <= 0;   // back to acquiring
        end else if (peakValid) begin
            peakCnt   <= peakCnt + 1;
            lastPixel <= peak.pixel;
        end
    end

    noPeakWhileReady: assert property (@(posedge clk) disable iff (!res)
        peakValid |-> !ready)
        else $error("peak result while ready is high");

    quietInReset: assert property (@(posedge clk) !res |-> !ready && !wr.en)
        else $error("ready or RAM write active during reset");

    firstPixelZero: assert property (@(posedge clk) disable iff (!res)
        peakValid && peakCnt == 0 |-> peak.pixel == '0)
        else $error("scan did not start with pixel 0");

    pixelStep: assert property (@(posedge clk) disable iff (!res)
        peakValid && peakCnt != 0 |-> peak.pixel == pixelT'(lastPixel + 1'b1))
        else $error("peak pixel did not advance by one");

    pixelInRange: assert property (@(posedge clk) disable iff (!res)
        peakValid |-> peakCnt < numPixels)
        else $error("more results than active pixels in one scan");

endmodule

bind sifhTop sifhProps #(
    .numPixels(numPixels)
) sifhProps_i (
    .clk       (clk),
    .res       (res),
    .ready     (ready),
    .wr        (wr),
    .peakValid (peakValid),
    .peak      (peak)
);

//--- sifhTb.sv
`timescale 1ns/1ns

module sifhTb
    import sifhGeomPkg::*;
    import sifhCtrlPkg::*;
;

    localparam int numPix       = 8;
    localparam int readyTimeout = 400;   // 128 clear writes plus margin
    localparam int peakTimeout  = 64;    // one pixel is 16 reads
    localparam int countLimit   = (1 << countBits) - 1;

    logic clk;
    logic res;
    logic hitValid;
    hitT  hit;
    logic scan;
    logic ready;
    logic peakValid;
    peakT peak;

    int          refCount [numPix][numBins];   // reference histogram
    int unsigned lcgState;

    sifhTop #(
        .numPixels(numPix)
    ) sifhTop_i (
        .clk       (clk),
        .res       (res),
        .hitValid  (hitValid),
        .hit       (hit),
        .scan      (scan),
        .ready     (ready),
        .peakValid (peakValid),
        .peak      (peak)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic int unsigned nextRand();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return lcgState >> 16;   // upper bits are the better ones
    endfunction

    // random timestamp inside a given bin
    function automatic timeT stampIn(input int b);
        timeT ts;
        ts = timeT'(nextRand());
        ts[timeBits-1 -: binBits] = binT'(b);
        return ts;
    endfunction

    function automatic void clearModel();
        for (int p = 0; p < numPix; p++) begin
            for (int b = 0; b < numBins; b++) begin
                refCount[p][b] = 0;
            end
        end
    endfunction

    function automatic void countHit(input int pix, input timeT ts);
        int b;
        b = int'(ts[timeBits-1 -: binBits]);
        if (refCount[pix][b] < countLimit) begin
            refCount[pix][b]++;   // saturates at the top count
        end
    endfunction

    // highest count wins, lowest bin on a tie
    function automatic peakT expectedPeak(input int pix);
        int   bestBin;
        int   bestCnt;
        peakT want;
        bestBin = 0;
        bestCnt = refCount[pix][0];
        for (int b = 1; b < numBins; b++) begin
            if (refCount[pix][b] > bestCnt) begin
                bestBin = b;
                bestCnt = refCount[pix][b];
            end
        end
        want.pixel = pixelT'(pix);
        want.bin   = binT'(bestBin);
        want.count = countT'(bestCnt);
        return want;
    endfunction

    task automatic nextCycle();
        @(posedge clk);
        #2;
    endtask

    task automatic abortRun(input string why);
        $display("Verification failed");
        $fatal(1, "%s", why);
    endtask

    // the hit counts only if ready is high at the coming edge
    task automatic sendHit(input int pix, input timeT ts);
        hitValid      = 1'b1;
        hit.pixel     = pixelT'(pix);
        hit.timestamp = ts;
        if (ready) begin
            countHit(pix, ts);
        end
        nextCycle();
        hitValid = 1'b0;
    endtask

    task automatic randomHits(input int num);
        int gap;
        for (int i = 0; i < num; i++) begin
            sendHit(int'(nextRand() % numPix), timeT'(nextRand()));
            gap = int'(nextRand() % 4);
            repeat (gap) nextCycle();
        end
    endtask

    // junk hits keep coming while the engine is busy
    task automatic waitReady(input bit junk);
        int n;
        n = 0;
        while (!ready && n < readyTimeout) begin
            hitValid      = junk;
            hit.pixel     = pixelT'(nextRand());
            hit.timestamp = timeT'(nextRand());
            nextCycle();
            n++;
        end
        hitValid = 1'b0;
        if (!ready) begin
            abortRun("ready did not rise within the clear timeout");
        end
    endtask

    task automatic waitPeak();
        int n;
        n = 0;
        while (!peakValid && n < peakTimeout) begin
            nextCycle();
            n++;
        end
        if (!peakValid) begin
            abortRun("no peak result arrived within the timeout");
        end
    endtask

    task automatic checkPeak(input int pix);
        peakT want;
        want = expectedPeak(pix);
        assert (peak === want) else begin
            $display("** Error @%0t: pixel %0d expected bin %0d count %0d",
                $time, pix, want.bin, want.count);
            $display("    got pixel %0d bin %0d count %0d", peak.pixel, peak.bin, peak.count);
            abortRun("peak result does not match the reference histogram");
        end
    endtask

    // scan pulse with an optional hit in the same cycle
    task automatic runScan(input bit withHit, input int pix, input timeT ts);
        if (!ready) begin
            abortRun("scan requested while the engine was not ready");
        end
        scan = 1'b1;
        if (withHit) begin
            hitValid      = 1'b1;
            hit.pixel     = pixelT'(pix);
            hit.timestamp = ts;
            countHit(pix, ts);
        end
        nextCycle();
        scan     = 1'b0;
        hitValid = 1'b0;
        for (int p = 0; p < numPix; p++) begin
            waitPeak();
            checkPeak(p);
            nextCycle();
        end
        clearModel();   // the engine clears itself after a scan
        waitReady(1'b1);
    endtask

    initial begin
        lcgState = 32'd47923;
        res      = 1'b0;
        hitValid = 1'b0;
        hit      = '0;
        scan     = 1'b0;
        clearModel();
        repeat (4) @(posedge clk);
        #2;
        res = 1'b1;

        // empty histogram after the reset clear
        waitReady(1'b0);
        runScan(1'b0, 0, '0);

        randomHits(200);
        runScan(1'b0, 0, '0);

        // back to back hits for forwarding and saturation
        repeat (300) sendHit(3, stampIn(5));
        repeat (20) sendHit(6, stampIn(9));
        for (int i = 0; i < 10; i++) begin
            sendHit(0, stampIn(2));
            sendHit(0, stampIn(7));
        end
        runScan(1'b0, 0, '0);

        // equal counts in two bins
        for (int i = 0; i < 7; i++) begin
            sendHit(1, stampIn(11));
            sendHit(1, stampIn(4));
        end
        for (int i = 0; i < 5; i++) begin
            sendHit(2, stampIn(15));
            nextCycle();
            sendHit(2, stampIn(0));
        end
        runScan(1'b0, 0, '0);

        // fresh acquisition after junk during the clear
        randomHits(40);
        runScan(1'b0, 0, '0);

        // only hit is the one on the scan cycle
        runScan(1'b1, 7, stampIn(12));

        $display("Verification passed");
        $finish;
    end

endmodule

//--- flist.f
sifhGeomPkg.sv
sifhCtrlPkg.sv
histRam.sv
histFsm.sv
peakFinder.sv
sifhTop.sv
sifhTop_props.sv
sifhTb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the histogram engine testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing -f flist.f --top-module sifhTb -o simv \
    && ./obj_dir/simv \
    || exit 1
